/* rtl/videoPkg.sv */
`default_nettype none

package videoPkg;

    // Screen coordinate or object position
    typedef logic [9:0] coordT;

    typedef logic [4:0] paletteIdxT;    // Index as stored in sprite memory
    typedef logic [2:0] healthT;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgbT;

    // --------------------
    // Palette
    // --------------------
    localparam int paletteSize = 20;

    // Entry 0 doubles as the transparent key
    localparam rgbT paletteTable [paletteSize] = '{
        24'hffffff, 24'h000000, 24'h323232, 24'h888888, 24'h7b100c,
        24'hff0000, 24'hc58564, 24'h4b1400, 24'hbb8044, 24'hc58f5c,
        24'hc99869, 24'hca6225, 24'hc25820, 24'hf79534, 24'hf9953b,
        24'hfb9533, 24'hfd9737, 24'hf5cea1, 24'h80be1f, 24'h93db24
    };

    localparam rgbT transparentColor = 24'hffffff;

    // --------------------
    // Background
    // --------------------
    localparam logic [7:0] skyGreen = 8'hbf;   // Blue channel fades with DrawX

    localparam logic [9:0] healthBarHeight = 10'd10;
    localparam logic [9:0] healthBarWidth = 10'd50;
    localparam logic [9:0] healthStep = 10'd10;      // Pixels per health point

    localparam rgbT healthFullColor = 24'h00ff00;
    localparam rgbT healthLostColor = 24'hff0000;

endpackage

`default_nettype wire

/* rtl/spritePkg.sv */
`default_nettype none

package spritePkg;

    localparam int enemyCount = 4;

    // Characters are 41 x 61 pixels around their position
    localparam logic [9:0] spriteHalfWidth = 10'd20;
    localparam logic [9:0] spriteHalfHeight = 10'd30;

    // --------------------
    // Sheet layout
    // --------------------
    localparam logic [9:0] sheetWidth = 10'd240;
    localparam int sheetSize = 72000;       // Words in sprite memory

    typedef logic [18:0] sheetAddrT;

    // Column offset of each pose
    localparam logic [9:0] idleCol = 10'd0;
    localparam logic [9:0] moveCol = 10'd40;
    localparam logic [9:0] attackCol = 10'd160;
    localparam logic [9:0] shieldCol = 10'd200;
    localparam logic [9:0] deadCol = 10'd40;

    // Row band per character and facing
    localparam logic [9:0] playerRightRow = 10'd0;
    localparam logic [9:0] playerLeftRow = 10'd60;
    localparam logic [9:0] enemyRightRow = 10'd120;
    localparam logic [9:0] enemyLeftRow = 10'd180;
    localparam logic [9:0] otherRow = 10'd240;   // Dead player

    // Keyboard codes that make the player walk
    localparam logic [7:0] keyLeft = 8'd4;
    localparam logic [7:0] keyRight = 8'd7;

    typedef enum logic [2:0] {
        Idle,
        Move,
        Attack,
        Shield,
        Dead
    } poseT;

    typedef enum logic [1:0] {
        None,
        Player,
        Enemy
    } layerT;

endpackage

`default_nettype wire

/* rtl/spriteSelector.sv */
`default_nettype none
`timescale 1ns/10ps

module spriteSelector (
    input  wire                                               Clk,
    input  wire                                               reset,
    input  wire                                               PixelValid,
    input  wire videoPkg::coordT                              DrawX,
    input  wire videoPkg::coordT                              DrawY,
    input  wire videoPkg::coordT                              PlayerX,
    input  wire videoPkg::coordT                              PlayerY,
    input  wire                                               PlayerRight,
    input  wire                                               PlayerAttack,
    input  wire                                               PlayerShield,
    input  wire                                               GameOver,
    input  wire [7:0]                                         Keycode,
    input  wire videoPkg::coordT [spritePkg::enemyCount-1:0]  EnemyX,
    input  wire videoPkg::coordT [spritePkg::enemyCount-1:0]  EnemyY,
    input  wire [spritePkg::enemyCount-1:0]                   EnemyRight,
    input  wire [spritePkg::enemyCount-1:0]                   EnemyAttack,
    input  wire [spritePkg::enemyCount-1:0]                   EnemyShield,
    input  wire [spritePkg::enemyCount-1:0]                   EnemyDead,
    output logic                                              SelValid,
    output spritePkg::layerT                                  SelLayer,
    output videoPkg::coordT                                   SheetX,
    output videoPkg::coordT                                   SheetY,
    output videoPkg::coordT                                   SelDrawX,
    output videoPkg::coordT                                   SelDrawY
);

    import videoPkg::*;
    import spritePkg::*;

    logic playerHit;
    logic playerMove;
    logic [enemyCount-1:0] enemyHit;

    layerT layerNext;
    poseT poseNext;
    logic faceRight;
    coordT objX;
    coordT objY;
    coordT poseCol;
    coordT bandRow;
    coordT localCol;
    coordT localRow;

    // Box test around a character centre
    function automatic logic covers(input coordT pixX, input coordT pixY,
                                    input coordT posX, input coordT posY);
        coordT distX;
        coordT distY;
        distX = (pixX >= posX) ? pixX - posX : posX - pixX;
        distY = (pixY >= posY) ? pixY - posY : posY - pixY;
        return (distX <= spriteHalfWidth) && (distY <= spriteHalfHeight);
    endfunction

    // --------------------
    // Hit tests
    // --------------------
    assign playerHit = covers(DrawX, DrawY, PlayerX, PlayerY);
    assign playerMove = PlayerRight ? (Keycode == keyRight) : (Keycode == keyLeft);

    always_comb
    begin
        for (int i = 0; i < enemyCount; i++)
        begin
            enemyHit[i] = covers(DrawX, DrawY, EnemyX[i], EnemyY[i]) && !EnemyDead[i];
        end
    end

    // Priority and pose
    always_comb
    begin
        layerNext = None;
        poseNext = Idle;
        faceRight = PlayerRight;
        objX = PlayerX;
        objY = PlayerY;
        if (playerHit)
        begin
            layerNext = Player;
            if (playerMove)
                poseNext = Move;
            else if (PlayerAttack)
                poseNext = Attack;
            else if (PlayerShield)
                poseNext = Shield;
            else if (GameOver)
                poseNext = Dead;
        end
        else
        begin
            // Walk downward so the lowest index ends up on top
            for (int i = enemyCount - 1; i >= 0; i--)
            begin
                if (enemyHit[i])
                begin
                    layerNext = Enemy;
                    faceRight = EnemyRight[i];
                    objX = EnemyX[i];
                    objY = EnemyY[i];
                    if (EnemyAttack[i])
                        poseNext = Attack;
                    else if (EnemyShield[i])
                        poseNext = Shield;
                    else
                        poseNext = Move;
                end
            end
        end
    end

    // --------------------
    // Sheet placement
    // --------------------
    always_comb
    begin
        case (poseNext)
            Move:    poseCol = moveCol;
            Attack:  poseCol = attackCol;
            Shield:  poseCol = shieldCol;
            Dead:    poseCol = deadCol;
            default: poseCol = idleCol;
        endcase
        if (poseNext == Dead)
            bandRow = otherRow;
        else if (layerNext == Player)
            bandRow = faceRight ? playerRightRow : playerLeftRow;
        else
            bandRow = faceRight ? enemyRightRow : enemyLeftRow;
    end

    assign localCol = DrawX - (objX - spriteHalfWidth);
    assign localRow = DrawY - (objY - spriteHalfHeight);

    always_ff @(posedge Clk)
    begin
        if (reset)
        begin
            SelValid <= 1'b0;
            SelLayer <= None;
        end
        else
        begin
            SelValid <= PixelValid;
            SelLayer <= PixelValid ? layerNext : None;
        end
    end

    always_ff @(posedge Clk)
    begin
        SheetX <= poseCol + localCol;
        SheetY <= bandRow + localRow;
        SelDrawX <= DrawX;
        SelDrawY <= DrawY;
    end

    // Enemies have no dead frame, dead ones are skipped instead
    enemyNeverDead: assert property (@(posedge Clk) disable iff (reset)
        (PixelValid && layerNext == Enemy) |-> (poseNext != Dead));

endmodule

`default_nettype wire

/* rtl/sheetFetch.sv */
`default_nettype none
`timescale 1ns/10ps

module sheetFetch (
    input  wire                         Clk,
    input  wire                         reset,
    input  wire                         SelValid,
    input  wire spritePkg::layerT       SelLayer,
    input  wire videoPkg::coordT        SheetX,
    input  wire videoPkg::coordT        SheetY,
    input  wire videoPkg::coordT        SelDrawX,
    input  wire videoPkg::coordT        SelDrawY,
    output logic                        ReadEnable,
    output spritePkg::sheetAddrT        ReadAddress,
    output logic                        FetchValid,
    output spritePkg::layerT            FetchLayer,
    output videoPkg::coordT             FetchDrawX,
    output videoPkg::coordT             FetchDrawY
);

    import spritePkg::*;

    // --------------------
    // Memory request
    // --------------------
    // Row major, one word per sheet pixel
    assign ReadAddress = sheetAddrT'(SheetY) * sheetAddrT'(sheetWidth) + sheetAddrT'(SheetX);

    assign ReadEnable = SelValid && (SelLayer != None);   // Background needs no read

    // --------------------
    // Context delay
    // --------------------
    // One stage, matching the memory latency
    always_ff @(posedge Clk)
    begin
        if (reset)
        begin
            FetchValid <= 1'b0;
            FetchLayer <= None;
        end
        else
        begin
            FetchValid <= SelValid;
            FetchLayer <= SelValid ? SelLayer : None;
        end
    end

    always_ff @(posedge Clk)
    begin
        FetchDrawX <= SelDrawX;
        FetchDrawY <= SelDrawY;
    end

    addrInSheet: assert property (@(posedge Clk) disable iff (reset)
        ReadEnable |-> (int'(ReadAddress) < sheetSize));

endmodule

`default_nettype wire

/* rtl/pixelColorizer.sv */
`default_nettype none
`timescale 1ns/10ps

module pixelColorizer (
    input  wire                         Clk,
    input  wire                         reset,
    input  wire                         FetchValid,
    input  wire spritePkg::layerT       FetchLayer,
    input  wire videoPkg::coordT        FetchDrawX,
    input  wire videoPkg::coordT        FetchDrawY,
    input  wire videoPkg::paletteIdxT   SpriteData,
    input  wire videoPkg::healthT       Health,
    output logic                        RgbValid,
    output logic [7:0]                  VgaR,
    output logic [7:0]                  VgaG,
    output logic [7:0]                  VgaB
);

    import videoPkg::*;
    import spritePkg::*;

    rgbT paletteColor;
    rgbT pixelColor;
    coordT healthPixels;
    logic spriteShown;
    logic inHealthBar;
    logic [7:0] skyBlue;

    // --------------------
    // Palette lookup
    // --------------------
    always_comb
    begin
        if (int'(SpriteData) < paletteSize)
            paletteColor = paletteTable[SpriteData];
        else
            paletteColor = transparentColor;   // Unused indices show through
    end

    assign spriteShown = (FetchLayer != None) && (paletteColor != transparentColor);

    // --------------------
    // Background
    // --------------------
    assign healthPixels = coordT'(Health) * healthStep;
    assign inHealthBar = (FetchDrawY <= healthBarHeight) && (FetchDrawX <= healthBarWidth);
    assign skyBlue = 8'hff - 8'(FetchDrawX >> 3);   // Darker towards the right

    always_comb
    begin
        if (spriteShown)
            pixelColor = paletteColor;
        else if (inHealthBar)
            pixelColor = (FetchDrawX <= healthPixels) ? healthFullColor : healthLostColor;
        else
            pixelColor = '{red: 8'h00, green: skyGreen, blue: skyBlue};
    end

    always_ff @(posedge Clk)
    begin
        if (reset)
            RgbValid <= 1'b0;
        else
            RgbValid <= FetchValid;
    end

    always_ff @(posedge Clk)
    begin
        VgaR <= pixelColor.red;
        VgaG <= pixelColor.green;
        VgaB <= pixelColor.blue;
    end

    noRgbAfterReset: assert property (@(posedge Clk) reset |=> !RgbValid);

endmodule

`default_nettype wire

/* rtl/spriteRenderer.sv */
`default_nettype none
`timescale 1ns/10ps

module spriteRenderer (
    input  wire                                               Clk,
    input  wire                                               reset,
    input  wire                                               PixelValid,
    input  wire videoPkg::coordT                              DrawX,
    input  wire videoPkg::coordT                              DrawY,
    input  wire videoPkg::coordT                              PlayerX,
    input  wire videoPkg::coordT                              PlayerY,
    input  wire                                               PlayerRight,
    input  wire                                               PlayerAttack,
    input  wire                                               PlayerShield,
    input  wire                                               GameOver,
    input  wire [7:0]                                         Keycode,
    input  wire videoPkg::healthT                             Health,
    input  wire videoPkg::coordT [spritePkg::enemyCount-1:0]  EnemyX,
    input  wire videoPkg::coordT [spritePkg::enemyCount-1:0]  EnemyY,
    input  wire [spritePkg::enemyCount-1:0]                   EnemyRight,
    input  wire [spritePkg::enemyCount-1:0]                   EnemyAttack,
    input  wire [spritePkg::enemyCount-1:0]                   EnemyShield,
    input  wire [spritePkg::enemyCount-1:0]                   EnemyDead,
    output logic                                              ReadEnable,
    output spritePkg::sheetAddrT                              ReadAddress,
    input  wire videoPkg::paletteIdxT                         SpriteData,
    output logic                                              RgbValid,
    output logic [7:0]                                        VgaR,
    output logic [7:0]                                        VgaG,
    output logic [7:0]                                        VgaB
);

    import videoPkg::*;
    import spritePkg::*;

    // Selector to fetch
    logic selValid;
    layerT selLayer;
    coordT sheetX;
    coordT sheetY;
    coordT selDrawX;
    coordT selDrawY;

    // Fetch to colorizer
    logic fetchValid;
    layerT fetchLayer;
    coordT fetchDrawX;
    coordT fetchDrawY;

    spriteSelector i_spriteSelector (
        .Clk(Clk), .reset(reset),
        .PixelValid(PixelValid), .DrawX(DrawX), .DrawY(DrawY),
        .PlayerX(PlayerX), .PlayerY(PlayerY), .PlayerRight(PlayerRight),
        .PlayerAttack(PlayerAttack), .PlayerShield(PlayerShield),
        .GameOver(GameOver), .Keycode(Keycode),
        .EnemyX(EnemyX), .EnemyY(EnemyY), .EnemyRight(EnemyRight),
        .EnemyAttack(EnemyAttack), .EnemyShield(EnemyShield), .EnemyDead(EnemyDead),
        .SelValid(selValid), .SelLayer(selLayer), .SheetX(sheetX), .SheetY(sheetY),
        .SelDrawX(selDrawX), .SelDrawY(selDrawY)
    );

    sheetFetch i_sheetFetch (
        .Clk(Clk), .reset(reset),
        .SelValid(selValid), .SelLayer(selLayer), .SheetX(sheetX), .SheetY(sheetY),
        .SelDrawX(selDrawX), .SelDrawY(selDrawY),
        .ReadEnable(ReadEnable), .ReadAddress(ReadAddress),
        .FetchValid(fetchValid), .FetchLayer(fetchLayer),
        .FetchDrawX(fetchDrawX), .FetchDrawY(fetchDrawY)
    );

    // SpriteData lines up with the fetch stage output
    pixelColorizer i_pixelColorizer (
        .Clk(Clk), .reset(reset),
        .FetchValid(fetchValid), .FetchLayer(fetchLayer),
        .FetchDrawX(fetchDrawX), .FetchDrawY(fetchDrawY),
        .SpriteData(SpriteData), .Health(Health),
        .RgbValid(RgbValid), .VgaR(VgaR), .VgaG(VgaG), .VgaB(VgaB)
    );

endmodule

`default_nettype wire

/* sim/tbSpriteRenderer.sv */
`default_nettype none
`timescale 1ns/10ps

module tbSpriteRenderer;

    import videoPkg::*;
    import spritePkg::*;

    localparam int drainTimeout = 20;   // Cycles to wait for the last pixels

    logic Clk;
    logic reset;
    logic PixelValid;
    coordT DrawX;
    coordT DrawY;
    coordT PlayerX;
    coordT PlayerY;
    logic PlayerRight;
    logic PlayerAttack;
    logic PlayerShield;
    logic GameOver;
    logic [7:0] Keycode;
    healthT Health;
    coordT [enemyCount-1:0] EnemyX;
    coordT [enemyCount-1:0] EnemyY;
    logic [enemyCount-1:0] EnemyRight;
    logic [enemyCount-1:0] EnemyAttack;
    logic [enemyCount-1:0] EnemyShield;
    logic [enemyCount-1:0] EnemyDead;
    logic ReadEnable;
    sheetAddrT ReadAddress;
    paletteIdxT SpriteData;
    logic RgbValid;
    logic [7:0] VgaR;
    logic [7:0] VgaG;
    logic [7:0] VgaB;

    logic forceIdx;             // Memory answers with forcedIdx
    paletteIdxT forcedIdx;
    logic readPending;
    sheetAddrT readAddr;
    rgbT expRgbQ [$];
    sheetAddrT expAddrQ [$];
    int rgbCycleQ [$];
    int addrCycleQ [$];
    int cycleCount = 0;
    int pixelCount = 0;
    int rgbCount = 0;
    int rgbErrors = 0;
    int addrErrors = 0;
    int otherErrors = 0;

    spriteRenderer i_spriteRenderer (.*);

    always #50 Clk = ~Clk;

    always @(posedge Clk)
    begin
        cycleCount++;
    end

    // --------------------
    // Sprite memory model
    // --------------------
    always @(negedge Clk)
    begin
        readPending <= ReadEnable;
        readAddr <= ReadAddress;
    end

    always @(posedge Clk)
    begin
        if (readPending === 1'b1)
            SpriteData <= forceIdx ? forcedIdx : paletteIdxT'(readAddr % paletteSize);
        else
            SpriteData <= paletteIdxT'(1 + $urandom % 19);   // Junk while no read is pending
    end

    task automatic checkRgb(input rgbT got, input rgbT expected);
        if (got !== expected)
        begin
            rgbErrors++;
            $display("Error at %0t: RGB %h, expected %h", $time, got, expected);
        end
    endtask

    task automatic checkAddress(input sheetAddrT got, input sheetAddrT expected);
        if (got !== expected)
        begin
            addrErrors++;
            $display("Error at %0t: ReadAddress %0d, expected %0d", $time, got, expected);
        end
    endtask

    // Each stage adds a fixed number of cycles
    task automatic verifyLatency(input string what, input int dueCycle);
        if (cycleCount != dueCycle)
        begin
            otherErrors++;
            $display("%s came in cycle %0d instead of cycle %0d", what, cycleCount,
                dueCycle);
        end
    endtask

    // Outputs sampled mid cycle
    always @(negedge Clk)
    begin
        if (!reset && RgbValid === 1'b1)
        begin
            rgbCount++;
            if (expRgbQ.size() == 0)
            begin
                otherErrors++;
                $display("RGB output at %0t with no pixel pending", $time);
            end
            else
            begin
                checkRgb({VgaR, VgaG, VgaB}, expRgbQ.pop_front());
                verifyLatency("RGB output", rgbCycleQ.pop_front());
            end
        end
        if (!reset && ReadEnable === 1'b1)
        begin
            if (expAddrQ.size() == 0)
            begin
                otherErrors++;
                $display("Sprite read at %0t for a pixel without a sprite", $time);
            end
            else
            begin
                checkAddress(ReadAddress, expAddrQ.pop_front());
                verifyLatency("Sprite read", addrCycleQ.pop_front());
            end
        end
    end

    // --------------------
    // Reference rules
    // --------------------
    function automatic bit covered(input int cx, input int cy);
        int dx;
        int dy;
        dx = int'(DrawX) - cx;
        dy = int'(DrawY) - cy;
        return (dx >= -int'(spriteHalfWidth)) && (dx <= int'(spriteHalfWidth))
            && (dy >= -int'(spriteHalfHeight)) && (dy <= int'(spriteHalfHeight));
    endfunction

    function automatic bit findSprite(output sheetAddrT addr);
        bit found;
        int col;
        int row;
        int cx;
        int cy;
        found = 1'b0;
        col = 0;
        row = 0;
        cx = 0;
        cy = 0;
        if (covered(int'(PlayerX), int'(PlayerY)))
        begin
            found = 1'b1;
            cx = int'(PlayerX);
            cy = int'(PlayerY);
            row = PlayerRight ? int'(playerRightRow) : int'(playerLeftRow);
            if (Keycode == (PlayerRight ? keyRight : keyLeft))
                col = int'(moveCol);
            else if (PlayerAttack)
                col = int'(attackCol);
            else if (PlayerShield)
                col = int'(shieldCol);
            else if (GameOver)
            begin
                col = int'(deadCol);
                row = int'(otherRow);
            end
            else
                col = int'(idleCol);
        end
        for (int i = 0; i < enemyCount; i++)
        begin
            if (!found && !EnemyDead[i] && covered(int'(EnemyX[i]), int'(EnemyY[i])))
            begin
                found = 1'b1;
                cx = int'(EnemyX[i]);
                cy = int'(EnemyY[i]);
                row = EnemyRight[i] ? int'(enemyRightRow) : int'(enemyLeftRow);
                if (EnemyAttack[i])
                    col = int'(attackCol);
                else if (EnemyShield[i])
                    col = int'(shieldCol);
                else
                    col = int'(moveCol);
            end
        end
        addr = sheetAddrT'((row + int'(DrawY) - cy + int'(spriteHalfHeight)) * int'(sheetWidth)
            + col + int'(DrawX) - cx + int'(spriteHalfWidth));
        return found;
    endfunction

    function automatic rgbT expectedColor(input bit sprite, input sheetAddrT addr);
        rgbT color;
        int idx;
        idx = forceIdx ? int'(forcedIdx) : int'(addr % paletteSize);
        color = sprite ? paletteTable[idx] : transparentColor;
        if (color != transparentColor)
            return color;
        if (DrawY <= healthBarHeight && DrawX <= healthBarWidth)
            return (int'(DrawX) <= int'(Health) * 10) ? 24'h00ff00 : 24'hff0000;
        return {8'h00, skyGreen, 8'(255 - int'(DrawX) / 8)};   // Sky gradient
    endfunction

    // Read is due one cycle after the pixel, colour three cycles after it
    task automatic recordExpected();
        sheetAddrT addr;
        bit sprite;
        sprite = findSprite(addr);
        if (sprite)
        begin
            expAddrQ.push_back(addr);
            addrCycleQ.push_back(cycleCount + 1);
        end
        expRgbQ.push_back(expectedColor(sprite, addr));
        rgbCycleQ.push_back(cycleCount + 3);
    endtask

    // Called on a rising edge, returns on the next one
    task automatic sendPixel(input int x, input int y);
        DrawX <= coordT'(x);
        DrawY <= coordT'(y);
        PixelValid <= 1'b1;
        pixelCount++;
        @(negedge Clk);
        recordExpected();
        @(posedge Clk);
    endtask

    task automatic drainPipeline();
        int cycles;
        cycles = 0;
        PixelValid <= 1'b0;
        while (expRgbQ.size() != 0 && cycles < drainTimeout)
        begin
            @(negedge Clk);
            cycles++;
        end
        if (expRgbQ.size() != 0)
        begin
            otherErrors++;
            $display("Timeout: %0d pixels never produced an RGB output", expRgbQ.size());
            expRgbQ.delete();
            rgbCycleQ.delete();
        end
        if (expAddrQ.size() != 0)
        begin
            otherErrors++;
            $display("%0d sprite pixels never issued a memory read", expAddrQ.size());
            expAddrQ.delete();
            addrCycleQ.delete();
        end
        @(posedge Clk);
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic backgroundPixels();
        healthT levels [4] = '{3'd0, 3'd2, 3'd4, 3'd7};
        EnemyDead <= '1;
        PlayerX <= 10'd600;
        PlayerY <= 10'd400;
        foreach (levels[k])
        begin
            Health <= levels[k];
            sendPixel(0, 0);
            sendPixel(20, 5);
            sendPixel(21, 10);
            sendPixel(50, 10);
            sendPixel(51, 3);    // Just right of the bar
            sendPixel(30, 11);   // Just below it
            sendPixel(320, 240);
            sendPixel(639, 100);
            drainPipeline();
        end
    endtask

    task automatic playerPoses();
        EnemyDead <= '1;
        PlayerX <= 10'd150;
        PlayerY <= 10'd200;
        for (int dir = 0; dir < 2; dir++)
        begin
            for (int variant = 0; variant < 8; variant++)
            begin
                PlayerRight <= dir[0];
                if (variant == 1 || variant == 7)
                    Keycode <= dir[0] ? keyRight : keyLeft;
                else if (variant == 2)
                    Keycode <= dir[0] ? keyLeft : keyRight;   // Key for the other way
                else
                    Keycode <= 8'd0;
                PlayerAttack <= (variant == 3 || variant == 5 || variant == 7);
                PlayerShield <= (variant == 4);
                GameOver <= (variant == 5 || variant == 6);
                sendPixel(130, 170);
                sendPixel(150, 200);
                sendPixel(170, 229);
                sendPixel(141, 215);
                drainPipeline();
            end
        end
        GameOver <= 1'b0;
        PlayerAttack <= 1'b0;
        PlayerShield <= 1'b0;
        Keycode <= 8'd0;
    endtask

    task automatic enemyPriority();
        PlayerY <= 10'd250;
        EnemyX <= {10'd345, 10'd330, 10'd315, 10'd310};
        EnemyY <= {10'd270, 10'd262, 10'd255, 10'd250};
        EnemyRight <= 4'b1010;
        EnemyAttack <= 4'b0101;
        EnemyShield <= 4'b0011;
        for (int m = 0; m < 16; m++)
        begin
            EnemyDead <= 4'(m);
            PlayerX <= (m < 2) ? 10'd300 : 10'd800;   // Player overlaps only at first
            for (int x = 285; x <= 370; x += 7)
                sendPixel(x, 255);
            drainPipeline();
        end
    endtask

    task automatic transparentSprites();
        forceIdx <= 1'b1;
        forcedIdx <= 5'd0;
        Health <= 3'd2;
        PlayerX <= 10'd40;
        PlayerY <= 10'd35;
        EnemyDead <= 4'b1110;
        EnemyX <= {10'd900, 10'd900, 10'd900, 10'd400};
        EnemyY <= {10'd700, 10'd700, 10'd700, 10'd300};
        sendPixel(25, 8);
        sendPixel(45, 10);
        sendPixel(20, 5);
        sendPixel(55, 9);
        sendPixel(30, 40);
        sendPixel(400, 300);
        sendPixel(385, 280);
        drainPipeline();
        forcedIdx <= 5'd18;   // Opaque green
        sendPixel(40, 35);
        sendPixel(400, 300);
        drainPipeline();
        forceIdx <= 1'b0;
    endtask

    task automatic streamRandomPixels();
        int px;
        int py;
        int x;
        int y;
        Health <= 3'd4;
        for (int n = 0; n < 200; n++)
        begin
            px = 60 + $urandom % 520;
            py = 60 + $urandom % 360;
            x = px - 25 + $urandom % 51;
            y = py - 30 + $urandom % 60;   // Last dead row lies outside the sheet
            PlayerX <= coordT'(px);
            PlayerY <= coordT'(py);
            PlayerRight <= 1'($urandom);
            PlayerAttack <= 1'($urandom);
            PlayerShield <= 1'($urandom);
            GameOver <= 1'($urandom);
            case ($urandom % 3)
                0: Keycode <= 8'd0;
                1: Keycode <= keyLeft;
                default: Keycode <= keyRight;
            endcase
            for (int i = 0; i < enemyCount; i++)
            begin
                EnemyX[i] <= coordT'(x - 20 + $urandom % 41);
                EnemyY[i] <= coordT'(y - 25 + $urandom % 51);
            end
            EnemyRight <= 4'($urandom);
            EnemyAttack <= 4'($urandom);
            EnemyShield <= 4'($urandom);
            EnemyDead <= 4'($urandom);
            sendPixel(x, y);
        end
        drainPipeline();
        if (rgbCount != pixelCount)
        begin
            otherErrors++;
            $display("Sent %0d pixels but saw %0d RGB outputs", pixelCount, rgbCount);
        end
    endtask

    initial
    begin
        void'($urandom(45));
        Clk = 1'b0;
        reset = 1'b1;
        PixelValid = 1'b0;
        DrawX = '0;
        DrawY = '0;
        PlayerX = '0;
        PlayerY = '0;
        PlayerRight = 1'b0;
        PlayerAttack = 1'b0;
        PlayerShield = 1'b0;
        GameOver = 1'b0;
        Keycode = 8'd0;
        Health = '0;
        EnemyX = '0;
        EnemyY = '0;
        EnemyRight = '0;
        EnemyAttack = '0;
        EnemyShield = '0;
        EnemyDead = '1;
        SpriteData = '0;
        forceIdx = 1'b0;
        forcedIdx = '0;
        repeat (4) @(posedge Clk);
        reset <= 1'b0;
        backgroundPixels();
        playerPoses();
        enemyPriority();
        transparentSprites();
        streamRandomPixels();
        $display("Errors: rgb %0d, address %0d, other %0d", rgbErrors, addrErrors, otherErrors);
        if (rgbErrors == 0 && addrErrors == 0 && otherErrors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
rtl/videoPkg.sv
rtl/spritePkg.sv
rtl/spriteSelector.sv
rtl/sheetFetch.sv
rtl/pixelColorizer.sv
rtl/spriteRenderer.sv
sim/tbSpriteRenderer.sv

/* run.sh */
#!/bin/sh
# Build and run the sprite renderer testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tbSpriteRenderer -o tbSpriteRenderer
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tbSpriteRenderer > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
    exit 1
fi
exit 0
